// File: apb_pkg.sv
// apb_pkg
// bus widths of the APB port and the registered request that the
// APB slave interface hands to the component side
package apb_pkg;

   // address covers the 4 KB peripheral window
   localparam int APB_ADDR_W = 12;
   localparam int APB_DATA_W = 32;
   // user attribute carries the initiator id
   localparam int APB_USER_W = 8;

   // request as captured in the setup phase, 53 bits
   typedef struct packed {
      logic [APB_ADDR_W-1:0] addr;
      // 1 for write, 0 for read
      logic                  write;
      // only loaded on writes, stale on reads
      logic [APB_DATA_W-1:0] wdata;
      logic [APB_USER_W-1:0] user;
   } sif_req_t;

endpackage

// File: crc_pkg.sv
// crc_pkg
// register map, CRC-32 constants and the decoded operation that the
// register decode stage passes to the engine and result stages
package crc_pkg;

   // crc state width and word count width in STATUS
   localparam int CRC_W = 32;
   localparam int CNT_W = 16;

   // register byte offsets
   localparam logic [11:0] REG_CTRL   = 12'h000;
   localparam logic [11:0] REG_DATA   = 12'h004;
   localparam logic [11:0] REG_RESULT = 12'h008;
   localparam logic [11:0] REG_STATUS = 12'h00C;

   // reflected crc-32, start and finish with all ones
   localparam logic [CRC_W-1:0] CRC_INIT   = 32'hFFFF_FFFF;
   localparam logic [CRC_W-1:0] CRC_XOROUT = 32'hFFFF_FFFF;

   // what a single request asks of the datapath
   typedef enum logic [2:0] {
      OP_NONE,
      OP_CLEAR,
      OP_FEED,
      OP_RD_RESULT,
      OP_RD_STATUS,
      OP_RD_CTRL,
      OP_ERR
   } crc_op_e;

   // op plus the write data that goes with it, 35 bits
   typedef struct packed {
      crc_op_e          op;
      logic [CRC_W-1:0] data;
   } crc_op_t;

endpackage

// File: apb_slv_sif.sv
// apb_slv_sif
// APB slave front end; registers the request in the setup phase and
// presents it with a dv strobe through the access phase, stalling the
// bus with pready while the component asserts hold
`timescale 1ns/100ps

module apb_slv_sif import apb_pkg::*; (
   input  logic                  pclk,
   input  logic                  rst_n,
   // APB side
   input  logic [APB_ADDR_W-1:0] paddr,
   // protection attributes are accepted but not checked
   input  logic [2:0]            pprot,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_DATA_W-1:0] pwdata,
   input  logic [APB_USER_W-1:0] pauser,
   output logic                  pready,
   output logic                  pslverr,
   output logic [APB_DATA_W-1:0] prdata,
   // component side
   output sif_req_t              req,
   output logic                  dv,
   input  logic                  hold,
   input  logic                  slverr,
   input  logic [APB_DATA_W-1:0] rdata
);

   logic setup_phase;
   logic access_phase;
   logic valid_access;

   // setup is select without enable, access is select with enable
   assign setup_phase  = psel & ~penable;
   assign access_phase = psel & penable;
   assign valid_access = dv & access_phase;

   // request payload, held steady until the next setup phase
   always_ff @(posedge pclk) begin
      if (setup_phase) begin
         req.addr  <= paddr;
         req.write <= pwrite;
         req.user  <= pauser;
      end
      // write data only matters for writes
      if (setup_phase && pwrite) begin
         req.wdata <= pwdata;
      end
   end

   // dv rises after setup and drops once the access completes
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         dv <= 1'b0;
      end else if (setup_phase || (access_phase && pready)) begin
         dv <= setup_phase;
      end
   end

   // stall only a valid access that the component holds
   assign pready  = valid_access ? ~hold : 1'b1;
   assign prdata  = valid_access ? rdata : '0;
   // an access with no setup before it is an error by itself
   assign pslverr = valid_access ? slverr : access_phase;

endmodule

// File: crc_reg_decode.sv
// crc_reg_decode
// turns a registered bus request into a CRC operation; wrong direction,
// unmapped offsets and writes from foreign users all become OP_ERR
`timescale 1ns/100ps

module crc_reg_decode import apb_pkg::*, crc_pkg::*; #(
   // only this initiator may write
   parameter logic [APB_USER_W-1:0] ALLOWED_USER = 8'h01
) (
   input  sif_req_t req,
   output crc_op_t  op
);

   logic user_ok;

   assign user_ok = (req.user == ALLOWED_USER);

   always_comb begin
      // data passes through untouched, only feed and ctrl use it
      op.data = req.wdata;
      op.op   = OP_ERR;
      case (req.addr)
         REG_CTRL: begin
            if (!req.write) begin
               op.op = OP_RD_CTRL;
            end else if (user_ok) begin
               // writing 0 to bit 0 is a legal no-op
               op.op = req.wdata[0] ? OP_CLEAR : OP_NONE;
            end
         end
         REG_DATA: begin
            // write only register
            if (req.write && user_ok) begin
               op.op = OP_FEED;
            end
         end
         REG_RESULT: begin
            if (!req.write) begin
               op.op = OP_RD_RESULT;
            end
         end
         REG_STATUS: begin
            if (!req.write) begin
               op.op = OP_RD_STATUS;
            end
         end
         default: begin
            // anything else in the window is unmapped
            op.op = OP_ERR;
         end
      endcase
   end

endmodule

// File: crc_engine.sv
// crc_engine
// reflected CRC-32 state and word counter; a fed word is folded one
// byte per cycle, low byte first, so busy lasts four cycles per word
`timescale 1ns/100ps

module crc_engine import crc_pkg::*; #(
   // reflected generator polynomial
   parameter logic [CRC_W-1:0] POLY = 32'hEDB8_8320
) (
   input  logic             pclk,
   input  logic             rst_n,
   input  logic             fire,
   input  crc_op_t          op,
   output logic             busy,
   output logic [CRC_W-1:0] crc,
   output logic [CNT_W-1:0] count
);

   logic [CRC_W-1:0] crc_q;
   logic [CRC_W-1:0] word_q;
   logic [1:0]       byte_idx;
   logic             feed;

   // one byte through the bitwise lfsr, eight shifts
   function automatic logic [CRC_W-1:0] crc_byte(
      input logic [CRC_W-1:0] c,
      input logic [7:0]       b
   );
      logic [CRC_W-1:0] r;
      r = c ^ {{(CRC_W-8){1'b0}}, b};
      for (int i = 0; i < 8; i++) begin
         // reflected form shifts right and xors on the dropped bit
         r = r[0] ? ((r >> 1) ^ POLY) : (r >> 1);
      end
      return r;
   endfunction

   // result stage never fires a feed while busy
   assign feed = fire && (op.op == OP_FEED);

   // control state and running crc
   always_ff @(posedge pclk) begin
      if (!rst_n) begin
         crc_q    <= CRC_INIT;
         count    <= '0;
         busy     <= 1'b0;
         byte_idx <= 2'd0;
      end else if (busy) begin
         crc_q    <= crc_byte(crc_q, word_q[7:0]);
         byte_idx <= byte_idx + 2'd1;
         // last byte of the word
         if (byte_idx == 2'd3) begin
            busy <= 1'b0;
         end
      end else if (fire) begin
         case (op.op)
            OP_CLEAR: begin
               crc_q <= CRC_INIT;
               count <= '0;
            end
            OP_FEED: begin
               count    <= count + 1'b1;
               busy     <= 1'b1;
               byte_idx <= 2'd0;
            end
            default: begin
               // reads and no-ops leave the state alone
               crc_q <= crc_q;
            end
         endcase
      end
   end

   // word buffer, shifted down a byte per busy cycle
   always_ff @(posedge pclk) begin
      if (feed) begin
         word_q <= op.data;
      end else if (busy) begin
         word_q <= word_q >> 8;
      end
   end

   // final xor applied on the way out
   assign crc = crc_q ^ CRC_XOROUT;

endmodule

// File: crc_result.sv
// crc_result
// answers the bus side; builds read data and the error flag, holds
// transfers that must wait for the engine, and fires accepted ops
`timescale 1ns/100ps

module crc_result import apb_pkg::*, crc_pkg::*; (
   input  logic                  dv,
   input  crc_op_t               op,
   input  logic                  busy,
   input  logic [CRC_W-1:0]      crc,
   input  logic [CNT_W-1:0]      count,
   output logic                  hold,
   output logic                  slverr,
   output logic [APB_DATA_W-1:0] rdata,
   output logic                  fire
);

   logic needs_idle;

   // ops that would race the byte loop wait for it to finish
   assign needs_idle = (op.op == OP_FEED) ||
                       (op.op == OP_CLEAR) ||
                       (op.op == OP_RD_RESULT);

   assign hold = dv & busy & needs_idle;

   // single cycle accept, errors never reach the engine
   assign fire = dv & ~hold & (op.op != OP_ERR);

   // error flag, the bus side masks it outside valid accesses
   assign slverr = (op.op == OP_ERR);

   always_comb begin
      case (op.op)
         OP_RD_RESULT: begin
            rdata = crc;
         end
         OP_RD_STATUS: begin
            // count on top, busy in bit 0
            rdata = {count, 15'b0, busy};
         end
         default: begin
            // ctrl reads back as zero, as do writes and errors
            rdata = '0;
         end
      endcase
   end

endmodule

// File: crc_apb_top.sv
// crc_apb_top
// CRC-32 peripheral on APB; bus interface, register decode, byte-serial
// engine and response stage wired together
`timescale 1ns/100ps

module crc_apb_top import apb_pkg::*, crc_pkg::*; #(
   parameter logic [CRC_W-1:0]      POLY         = 32'hEDB8_8320,
   parameter logic [APB_USER_W-1:0] ALLOWED_USER = 8'h01
) (
   input  logic                  pclk,
   input  logic                  rst_n,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  logic [2:0]            pprot,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_DATA_W-1:0] pwdata,
   input  logic [APB_USER_W-1:0] pauser,
   output logic                  pready,
   output logic                  pslverr,
   output logic [APB_DATA_W-1:0] prdata
);

   // interface to decode
   sif_req_t              req;
   logic                  dv;
   crc_op_t               op;
   // response back to the interface
   logic                  hold;
   logic                  slverr;
   logic [APB_DATA_W-1:0] rdata;
   // engine handshake and state
   logic                  fire;
   logic                  busy;
   logic [CRC_W-1:0]      crc;
   logic [CNT_W-1:0]      count;

   apb_slv_sif i_apb_slv_sif (
      .pclk, .rst_n, .paddr, .pprot, .psel, .penable, .pwrite, .pwdata, .pauser,
      .pready, .pslverr, .prdata, .req, .dv, .hold, .slverr, .rdata
   );

   crc_reg_decode #(.ALLOWED_USER(ALLOWED_USER)) i_crc_reg_decode (
      .req, .op
   );

   crc_engine #(.POLY(POLY)) i_crc_engine (
      .pclk, .rst_n, .fire, .op, .busy, .crc, .count
   );

   crc_result i_crc_result (
      .dv, .op, .busy, .crc, .count, .hold, .slverr, .rdata, .fire
   );

endmodule

// File: tb_crc_apb.sv
// tb_crc_apb
// directed testbench for the APB CRC-32 peripheral; drives APB transfers,
// keeps its own bitwise CRC model and checks read data and pslverr
`timescale 1ns/100ps

module tb_crc_apb import apb_pkg::*; ();

   localparam int               NUM_TESTS = 6;
   localparam logic [31:0]      REF_POLY  = 32'hEDB8_8320;
   localparam logic [APB_USER_W-1:0] GOOD_USER = 8'h01;

   logic                  pclk;
   logic                  rst_n;
   logic [APB_ADDR_W-1:0] paddr;
   logic [2:0]            pprot;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_DATA_W-1:0] pwdata;
   logic [APB_USER_W-1:0] pauser;
   logic                  pready;
   logic                  pslverr;
   logic [APB_DATA_W-1:0] prdata;

   int          errors;
   int          checks;
   logic [15:0] lfsr_state;
   // reference crc state before final xor, and the expected word count
   logic [31:0] model_state;
   logic [15:0] model_count;

   crc_apb_top i_crc_apb_top (
      .pclk, .rst_n, .paddr, .pprot, .psel, .penable, .pwrite, .pwdata, .pauser,
      .pready, .pslverr, .prdata
   );

   initial begin
      pclk = 1'b0;
      forever #4 pclk = ~pclk;
   end

   // x^16 + x^14 + x^13 + x^11, one shift per bit
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_word(output logic [31:0] w);
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w[i] = lfsr_state[0];
      end
   endtask

   // bit at a time, lsb first, reflected form
   function automatic logic [31:0] model_feed(input logic [31:0] s, input logic [31:0] w);
      logic fb;
      for (int i = 0; i < 32; i++) begin
         fb = s[0] ^ w[i];
         s  = s >> 1;
         if (fb) begin
            s = s ^ REF_POLY;
         end
      end
      return s;
   endfunction

   task automatic check_word(input string name, input logic [APB_DATA_W-1:0] exp,
                             input logic [APB_DATA_W-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Mismatch %s pslverr: expected %b, actual %b", name, exp, act);
      end
   endtask

   // one transfer from setup; samples the response mid-cycle once pready is high
   task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                               input logic [APB_DATA_W-1:0] wdata,
                               input logic [APB_USER_W-1:0] user,
                               output logic [APB_DATA_W-1:0] rdata, output logic err,
                               output int waits);
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      pauser  = user;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge pclk);
      #1 penable = 1'b1;
      waits = 0;
      @(negedge pclk);
      while (!pready) begin
         waits++;
         @(negedge pclk);
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge pclk);
      #1 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] d,
                            input logic [APB_USER_W-1:0] user, output logic err,
                            output int waits);
      logic [APB_DATA_W-1:0] unused_rd;
      apb_transfer(1'b1, addr, d, user, unused_rd, err, waits);
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [APB_DATA_W-1:0] d,
                           output logic err, output int waits);
      apb_transfer(1'b0, addr, '0, GOOD_USER, d, err, waits);
   endtask

   // feed one word to DATA and to the model
   task automatic feed_word(input string name, output int waits);
      logic [31:0] w;
      logic        err;
      rand_word(w);
      apb_write(12'h004, w, GOOD_USER, err, waits);
      check_err(name, 1'b0, err);
      model_state = model_feed(model_state, w);
      model_count = model_count + 16'd1;
   endtask

   task automatic clear_crc(input string name);
      logic err;
      int   waits;
      apb_write(12'h000, 32'h1, GOOD_USER, err, waits);
      check_err(name, 1'b0, err);
      model_state = 32'hFFFF_FFFF;
      model_count = 16'd0;
   endtask

   task automatic expect_result(input string name, output int waits);
      logic [31:0] d;
      logic        err;
      apb_read(12'h008, d, err, waits);
      check_err(name, 1'b0, err);
      check_word(name, model_state ^ 32'hFFFF_FFFF, d);
   endtask

   task automatic expect_status(input string name, input logic busy_exp);
      logic [31:0] d;
      logic        err;
      int          waits;
      apb_read(12'h00C, d, err, waits);
      check_err(name, 1'b0, err);
      check_word(name, {model_count, 15'b0, busy_exp}, d);
   endtask

   task automatic test_reset();
      int waits;
      expect_result("reset result", waits);
      expect_status("reset status", 1'b0);
   endtask

   task automatic test_checksum();
      int waits;
      clear_crc("checksum clear");
      for (int i = 0; i < 8; i++) begin
         feed_word("checksum feed", waits);
      end
      expect_result("checksum result", waits);
      expect_status("checksum status", 1'b0);
   endtask

   task automatic test_backpressure();
      int w0;
      int w1;
      int w2;
      feed_word("backpressure feed 0", w0);
      feed_word("backpressure feed 1", w1);
      expect_result("backpressure result", w2);
      checks++;
      if (w1 + w2 == 0) begin
         errors++;
         $display("Error: back-to-back transfers never saw pready low");
      end
   endtask

   task automatic test_busy();
      logic [31:0] d;
      logic        err;
      int          waits;
      feed_word("busy feed", waits);
      apb_read(12'h00C, d, err, waits);
      check_err("busy status", 1'b0, err);
      check_word("busy status", {model_count, 15'b0, 1'b1}, d);
      checks++;
      if (waits != 0) begin
         errors++;
         $display("Error: STATUS read during busy took %0d wait states", waits);
      end
      expect_result("busy result", waits);
   endtask

   task automatic test_errors();
      logic [31:0] d;
      logic        err;
      int          waits;
      apb_write(12'h010, 32'h1234_5678, GOOD_USER, err, waits);
      check_err("unmapped write", 1'b1, err);
      apb_write(12'h008, 32'h0, GOOD_USER, err, waits);
      check_err("result write", 1'b1, err);
      apb_read(12'h004, d, err, waits);
      check_err("data read", 1'b1, err);
      apb_write(12'h004, 32'hDEAD_BEEF, 8'h02, err, waits);
      check_err("foreign user write", 1'b1, err);
      expect_result("errors result", waits);
      expect_status("errors status", 1'b0);
   endtask

   task automatic test_clear();
      int waits;
      clear_crc("clear ctrl");
      feed_word("clear feed", waits);
      expect_result("clear result", waits);
      expect_status("clear status", 1'b0);
   endtask

   // run limit scales with the number of tests
   initial begin
      #(NUM_TESTS * 2000);
      $display("Error: watchdog expired before the tests finished");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      errors      = 0;
      checks      = 0;
      lfsr_state  = 16'd26;
      model_state = 32'hFFFF_FFFF;
      model_count = 16'd0;
      rst_n       = 1'b0;
      paddr       = '0;
      pprot       = 3'b000;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      pauser      = '0;
      repeat (4) @(posedge pclk);
      #1 rst_n = 1'b1;
      test_reset();
      test_checksum();
      test_backpressure();
      test_busy();
      test_errors();
      test_clear();
      $display("checks: %0d errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
apb_pkg.sv
crc_pkg.sv
apb_slv_sif.sv
crc_reg_decode.sv
crc_engine.sv
crc_result.sv
crc_apb_top.sv
tb_crc_apb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f all.f --top-module tb_crc_apb -o tb_crc_apb &&
./obj_dir/tb_crc_apb | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
